/* common/boot_settings.svh */
`ifndef BOOT_SETTINGS_SVH
`define BOOT_SETTINGS_SVH

// SPI timing.
`define SPI_CLK_DIV 2 // pin_clk cycles per SPI clock half-period.

// Reconfiguration delay.
`define BOOT_DELAY_BITS 9 // Top bit of the delay counter pulls programn low.

// Host transfer limits.
`define MAX_XFER_LEN 255 // Largest write or read length of one flash command.

`endif

/* common/boot_pkg.sv */
`default_nettype none

package boot_pkg;

  // Host command opcodes, first byte of every command.
  typedef enum logic [7:0] {
    cmd_boot  = 8'h01, // Start the delayed reconfiguration.
    cmd_flash = 8'h02  // Flash pass-through, followed by W, R and W data bytes.
  } boot_cmd_e;

  // Command engine states.
  typedef enum logic [2:0] {
    st_idle,     // Waiting for an opcode.
    st_get_wlen, // Next host byte is the write length.
    st_get_rlen, // Next host byte is the read length.
    st_write,    // Passing host bytes to the flash.
    st_read      // Clocking bytes out of the flash back to the host.
  } engine_state_e;

endpackage

`default_nettype wire

/* common/spi_xfer_if.sv */
`timescale 1ns/100ps
`default_nettype none

// One SPI byte transfer between the command engine and the SPI master.
interface spi_xfer_if;
  logic       start;   // One-cycle request, master must be idle.
  logic [7:0] tx_byte; // Byte to shift out, valid with start.
  logic [7:0] rx_byte; // Byte shifted in, valid with done.
  logic       done;    // One-cycle pulse after the eighth bit is sampled.
  logic       hold_cs; // Low means cs rises after this byte.

  modport engine (
    output start,
    output tx_byte,
    output hold_cs,
    input  rx_byte,
    input  done
  );

  modport master (
    input  start,
    input  tx_byte,
    input  hold_cs,
    output rx_byte,
    output done
  );
endinterface

`default_nettype wire

/* bootloader/cmd_engine.sv */
`timescale 1ns/100ps
`default_nettype none

`include "boot_settings.svh"

module cmd_engine import boot_pkg::*; (
  input  wire        pin_clk,
  input  wire        rst_n,
  input  wire        rx_valid, // Host byte strobe.
  input  wire  [7:0] rx_data,
  output logic       tx_valid, // Read byte strobe to the host.
  output logic [7:0] tx_data,
  output logic       busy,     // High while a byte is on the SPI bus.
  output logic       boot_req, // One-cycle pulse on cmd_boot.
  spi_xfer_if.engine spi
);

  localparam int LEN_W = $clog2(`MAX_XFER_LEN + 1); // Length counter width.

  engine_state_e    state;
  logic [LEN_W-1:0] wlen_cnt; // Write bytes still to come from the host.
  logic [LEN_W-1:0] rlen_cnt; // Read bytes still to return.
  logic             rx_take;  // Host byte accepted this cycle.
  logic             wr_take;  // Accepted byte is flash write data.
  logic [LEN_W-1:0] rx_len;   // Host byte as a length.

  assign rx_take = rx_valid && !busy; // Bytes during busy are dropped.
  assign wr_take = rx_take && (state == st_write);
  assign rx_len  = LEN_W'(rx_data);

  // Command sequencing.
  always_ff @(posedge pin_clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= st_idle;
      wlen_cnt    <= '0;
      rlen_cnt    <= '0;
      busy        <= 1'b0;
      boot_req    <= 1'b0;
      tx_valid    <= 1'b0;
      spi.start   <= 1'b0;
      spi.hold_cs <= 1'b0;
    end else begin
      boot_req  <= 1'b0; // Strobes default low.
      tx_valid  <= 1'b0;
      spi.start <= 1'b0;
      case (state)
        st_idle: begin
          if (rx_take) begin
            if (rx_data == cmd_boot) begin
              boot_req <= 1'b1;
            end else if (rx_data == cmd_flash) begin
              state <= st_get_wlen;
            end // Unknown opcodes fall through.
          end
        end
        st_get_wlen: begin
          if (rx_take) begin
            wlen_cnt <= rx_len;
            state    <= st_get_rlen;
          end
        end
        st_get_rlen: begin
          if (rx_take) begin
            rlen_cnt <= rx_len;
            if (wlen_cnt != '0) begin
              state <= st_write; // Busy stays low for the first data byte.
            end else if (rx_len != '0) begin
              state       <= st_read; // Read only, first dummy byte now.
              busy        <= 1'b1;
              spi.start   <= 1'b1;
              spi.hold_cs <= (rx_len != LEN_W'(1));
            end else begin
              state <= st_idle; // Empty command, cs untouched.
            end
          end
        end
        st_write: begin
          if (wr_take) begin
            busy        <= 1'b1;
            spi.start   <= 1'b1;
            spi.hold_cs <= !((wlen_cnt == LEN_W'(1)) && (rlen_cnt == '0)); // Last of all.
            wlen_cnt    <= wlen_cnt - LEN_W'(1);
          end else if (spi.done) begin
            if (wlen_cnt != '0) begin
              busy <= 1'b0; // Ready for the next write byte.
            end else if (rlen_cnt != '0) begin
              state       <= st_read; // Go straight on, cs still low.
              spi.start   <= 1'b1;
              spi.hold_cs <= (rlen_cnt != LEN_W'(1));
            end else begin
              state <= st_idle;
              busy  <= 1'b0;
            end
          end
        end
        st_read: begin
          if (spi.done) begin
            tx_valid <= 1'b1; // Return the byte one cycle after done.
            rlen_cnt <= rlen_cnt - LEN_W'(1);
            if (rlen_cnt != LEN_W'(1)) begin
              spi.start   <= 1'b1;
              spi.hold_cs <= (rlen_cnt != LEN_W'(2));
            end else begin
              state <= st_idle;
              busy  <= 1'b0;
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Payload bytes toward the flash and the host.
  always_ff @(posedge pin_clk) begin
    if (wr_take) begin
      spi.tx_byte <= rx_data; // Host data goes to the flash.
    end else if (spi.done || (state == st_get_rlen)) begin
      spi.tx_byte <= 8'h00; // Dummy byte for any read transfer.
    end
    if ((state == st_read) && spi.done) begin
      tx_data <= spi.rx_byte;
    end
  end

endmodule

`default_nettype wire

/* bootloader/spi_master.sv */
`timescale 1ns/100ps
`default_nettype none

`include "boot_settings.svh"

module spi_master (
  input  wire        pin_clk,
  input  wire        rst_n,
  spi_xfer_if.master spi,
  input  wire        miso,
  output logic       cs,   // Active low chip select.
  output logic       sck,  // Mode 0, idles low.
  output logic       mosi
);

  localparam int DIV_W = $clog2(`SPI_CLK_DIV + 1); // Divider counter width.
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SPI_CLK_DIV - 1);

  logic             active;   // Sixteen half-periods in progress.
  logic             finish;   // One cycle between last edge and done.
  logic             hold_q;   // Keep cs low after this byte.
  logic [DIV_W-1:0] div_cnt;  // Cycles within a half-period.
  logic [3:0]       half_cnt; // Half-period index.
  logic             edge_now; // sck toggles at this clock.
  logic             accept;   // New transfer starts.
  logic [7:0]       shift_q;  // Out bits at the top, in bits at the bottom.
  logic             miso_q;   // Bit sampled on the rising sck edge.

  assign edge_now    = active && (div_cnt == DIV_LAST);
  assign accept      = spi.start && !active && !finish;
  assign mosi        = active && shift_q[7]; // MSB first, low between bytes.
  assign spi.rx_byte = shift_q;

  // Clock divider, edge counting and chip select.
  always_ff @(posedge pin_clk or negedge rst_n) begin
    if (!rst_n) begin
      active   <= 1'b0;
      finish   <= 1'b0;
      hold_q   <= 1'b0;
      div_cnt  <= '0;
      half_cnt <= '0;
      cs       <= 1'b1;
      sck      <= 1'b0;
      spi.done <= 1'b0;
    end else begin
      spi.done <= 1'b0;
      if (accept) begin
        active   <= 1'b1;
        cs       <= 1'b0; // Falls on start, possibly already low.
        hold_q   <= spi.hold_cs;
        div_cnt  <= '0;
        half_cnt <= '0;
      end else if (active) begin
        if (edge_now) begin
          div_cnt  <= '0;
          sck      <= ~sck;
          half_cnt <= half_cnt + 4'd1;
          if (half_cnt == 4'd15) begin
            active <= 1'b0; // Final falling edge.
            finish <= 1'b1;
          end
        end else begin
          div_cnt <= div_cnt + DIV_W'(1);
        end
      end else if (finish) begin
        finish   <= 1'b0;
        spi.done <= 1'b1;
        if (!hold_q) begin
          cs <= 1'b1; // End of the flash command.
        end
      end
    end
  end

  // Data path, sample on rising sck and shift on falling sck.
  always_ff @(posedge pin_clk) begin
    if (accept) begin
      shift_q <= spi.tx_byte;
    end else if (edge_now) begin
      if (!sck) begin
        miso_q <= miso;
      end else begin
        shift_q <= {shift_q[6:0], miso_q}; // Next out bit moves to the top.
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/boot_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "boot_settings.svh"

module boot_sequencer (
  input  wire  pin_clk,
  input  wire  rst_n,
  input  wire  boot_req, // One-cycle request from the engine.
  output logic programn, // Low reconfigures the FPGA.
  output logic led       // Status LED.
);

  localparam int TOP     = `BOOT_DELAY_BITS - 1; // Expiry bit.
  localparam int LED_BIT = `BOOT_DELAY_BITS - 4; // Visible blink rate.

  logic                        boot_latched; // Request seen, held until reset.
  logic [`BOOT_DELAY_BITS-1:0] boot_delay;   // Counts up to the top bit.
  logic                        counting;

  assign counting = (boot_req || boot_latched) && !boot_delay[TOP]; // Stops when expired.
  assign programn = ~boot_delay[TOP];
  assign led      = (boot_latched && !boot_delay[TOP]) ? boot_delay[LED_BIT] : 1'b1;

  always_ff @(posedge pin_clk or negedge rst_n) begin
    if (!rst_n) begin
      boot_latched <= 1'b0;
      boot_delay   <= '0;
    end else begin
      if (boot_req) begin
        boot_latched <= 1'b1;
      end
      if (counting) begin
        boot_delay <= boot_delay + 1'b1; // Starts on the request cycle itself.
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/boot_top.sv */
`timescale 1ns/100ps
`default_nettype none

module boot_top (
  input  wire        pin_clk,
  input  wire        rst_n,
  input  wire        rx_valid,     // Host byte strobe.
  input  wire  [7:0] rx_data,      // Host byte.
  output logic       tx_valid,     // Byte strobe to the host.
  output logic [7:0] tx_data,      // Byte to the host.
  output logic       busy,         // Host must hold off while high.
  output logic       usb_tx_en,    // Host-link pad drive enable.
  output logic       pin_pu,       // Host-link pull-up.
  output logic       pin_led,
  output logic       pin_cs,
  output logic       pin_sck,
  output logic       pin_mosi,
  output logic       pin_io2,      // Flash write protect, kept inactive.
  output logic       pin_io3,      // Flash hold, kept inactive.
  output logic       pin_programn, // Low starts FPGA reconfiguration.
  input  wire        pin_miso
);

  logic boot_req; // One-cycle boot request from the engine.

  spi_xfer_if spi_bus (); // Byte transfers from engine to master.

  // Constant board pins.
  assign pin_pu  = 1'b1; // Host sees the device attached.
  assign pin_io2 = 1'b1;
  assign pin_io3 = 1'b1;

  // Pads turn around to drive only while a byte goes out.
  assign usb_tx_en = tx_valid;

  cmd_engine cmd_engine_i (
    .pin_clk  (pin_clk),
    .rst_n    (rst_n),
    .rx_valid (rx_valid),
    .rx_data  (rx_data),
    .tx_valid (tx_valid),
    .tx_data  (tx_data),
    .busy     (busy),
    .boot_req (boot_req),
    .spi      (spi_bus.engine)
  );

  spi_master spi_master_i (
    .pin_clk (pin_clk),
    .rst_n   (rst_n),
    .spi     (spi_bus.master),
    .miso    (pin_miso),
    .cs      (pin_cs),
    .sck     (pin_sck),
    .mosi    (pin_mosi)
  );

  boot_sequencer boot_sequencer_i (
    .pin_clk  (pin_clk),
    .rst_n    (rst_n),
    .boot_req (boot_req),
    .programn (pin_programn),
    .led      (pin_led)
  );

endmodule

`default_nettype wire

/* tests/flash_model.sv */
`timescale 1ns/100ps
`default_nettype none

// SPI mode-0 flash with read (03) and page program (02).
module flash_model (
  input  wire  cs,
  input  wire  sck,
  input  wire  mosi,
  output logic miso
);

  logic [7:0]  mem [0:4095]; // Small flash array, upper address bits ignored.
  logic [7:0]  cmd;          // Opcode of the current frame.
  logic [23:0] addr;         // Running address.
  logic [7:0]  in_sr;        // Bits received in this byte.
  logic [7:0]  out_sr;       // Byte being returned.
  logic [2:0]  bit_cnt;      // Bits received in this byte.
  int          byte_cnt;     // Bytes completed in this frame.
  int          i;

  initial begin
    for (i = 0; i < 4096; i++) begin
      mem[i] = 8'h5A ^ i[7:0] ^ {4'h0, i[11:8]}; // Depends on all twelve bits.
    end
    miso = 1'b0;
  end

  // New frame.
  always @(negedge cs) begin
    bit_cnt  = 3'd0;
    byte_cnt = 0;
    cmd      = 8'h00;
    out_sr   = 8'h00;
    miso    <= 1'b0;
  end

  // Sample on rising sck.
  always @(posedge sck) begin
    if (!cs) begin
      in_sr   = {in_sr[6:0], mosi};
      bit_cnt = bit_cnt + 3'd1;
      if (bit_cnt == 3'd0) begin
        if (byte_cnt == 0) begin
          cmd = in_sr; // Opcode byte.
        end else if (byte_cnt <= 3) begin
          addr = {addr[15:0], in_sr}; // Address, MSB first.
        end else if (cmd == 8'h02) begin
          mem[addr[11:0]] = in_sr; // Program data.
          addr = addr + 24'd1;
        end
        if ((cmd == 8'h03) && (byte_cnt >= 3)) begin
          out_sr = mem[addr[11:0]]; // Next read byte.
          addr   = addr + 24'd1;
        end else begin
          out_sr = 8'h00;
        end
        byte_cnt = byte_cnt + 1;
      end
    end
  end

  // Shift out on falling sck.
  always @(negedge sck) begin
    if (!cs) begin
      miso <= out_sr[3'd7 - bit_cnt];
    end
  end

endmodule

`default_nettype wire

/* tests/tb_boot.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_boot;

  localparam int WATCHDOG_NS = 200000; // Six tests, worst about 3000 cycles, big margin.

  logic       pin_clk;
  logic       rst_n;
  logic       rx_valid;
  logic [7:0] rx_data;
  logic       tx_valid;
  logic [7:0] tx_data;
  logic       busy;
  logic       usb_tx_en;
  logic       pin_pu;
  logic       pin_led;
  logic       pin_cs;
  logic       pin_sck;
  logic       pin_mosi;
  logic       pin_io2;
  logic       pin_io3;
  logic       pin_programn;
  logic       pin_miso;

  logic [7:0] tx_q [$];  // Bytes returned to the host.
  logic [7:0] pattern [0:15];
  logic [31:0] rng = 32'd81081;
  int         err_cnt = 0;
  int         test_err;  // Errors at test start.
  int         pass_cnt = 0;
  int         fail_cnt = 0;
  int         cs_rises = 0;
  logic       cs_prev = 1'b1;

  boot_top dut_i (
    .pin_clk(pin_clk), .rst_n(rst_n), .rx_valid(rx_valid), .rx_data(rx_data),
    .tx_valid(tx_valid), .tx_data(tx_data), .busy(busy), .usb_tx_en(usb_tx_en),
    .pin_pu(pin_pu), .pin_led(pin_led), .pin_cs(pin_cs), .pin_sck(pin_sck),
    .pin_mosi(pin_mosi), .pin_io2(pin_io2), .pin_io3(pin_io3),
    .pin_programn(pin_programn), .pin_miso(pin_miso)
  );

  flash_model flash_i (.cs(pin_cs), .sck(pin_sck), .mosi(pin_mosi), .miso(pin_miso));

  initial begin
    pin_clk = 1'b0;
    forever #4 pin_clk = ~pin_clk; // 8 ns period.
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired, the run timed out before all tests finished.");
    $display("Done: errors found");
    $finish;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic [7:0] fill_byte(input logic [11:0] a);
    return 8'h5A ^ a[7:0] ^ {4'h0, a[11:8]}; // Flash contents at power-up.
  endfunction

  task automatic report_error(input string msg);
    err_cnt++;
    $display("** Error at %0t ns: %s", $time, msg);
  endtask

  // Collect tx bytes and count cs rises.
  always @(posedge pin_clk) begin
    if (rst_n) begin
      if (tx_valid) tx_q.push_back(tx_data);
      if (pin_cs && !cs_prev) cs_rises++;
    end
    cs_prev <= pin_cs;
  end

  // Bus framing on every clock after reset.
  assert property (@(posedge pin_clk) disable iff (!rst_n) usb_tx_en == tx_valid)
    else report_error("usb_tx_en differs from tx_valid");
  assert property (@(posedge pin_clk) disable iff (!rst_n)
                   (pin_sck != $past(pin_sck)) |-> !pin_cs)
    else report_error("sck toggled while cs high");
  assert property (@(posedge pin_clk) disable iff (!rst_n) pin_sck |-> busy)
    else report_error("sck high while busy low");
  assert property (@(posedge pin_clk) disable iff (!rst_n) pin_cs |-> !pin_sck)
    else report_error("sck not low while idle");

  task automatic send_byte(input logic [7:0] b);
    @(posedge pin_clk);
    while (busy) @(posedge pin_clk);
    rx_valid <= 1'b1;
    rx_data  <= b;
    @(posedge pin_clk); // DUT takes the byte here.
    rx_valid <= 1'b0;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    repeat (2) @(posedge pin_clk);
    while (busy && n < 20000) begin
      @(posedge pin_clk);
      n++;
    end
    if (busy) report_error("flash command never finished, busy stuck high");
    repeat (4) @(posedge pin_clk);
  endtask

  task automatic read_cmd(input logic [11:0] a, input int len);
    send_byte(8'h02);
    send_byte(8'd4);
    send_byte(8'(len));
    send_byte(8'h03);
    send_byte(8'h00);
    send_byte({4'h0, a[11:8]});
    send_byte(a[7:0]);
  endtask

  task automatic check_read(input logic [11:0] a, input int len, input int rises0);
    assert (tx_q.size() == len) else report_error($sformatf("got %0d tx bytes", tx_q.size()));
    for (int k = 0; k < len && k < tx_q.size(); k++)
      assert (tx_q[k] == fill_byte(a + 12'(k)))
        else report_error($sformatf("read byte %0d is %h", k, tx_q[k]));
    assert (cs_rises == rises0 + 1) else report_error("cs did not rise once");
  endtask

  task automatic end_test(input string name);
    if (err_cnt == test_err) begin
      pass_cnt++;
      $display("Test %s: pass", name);
    end else begin
      fail_cnt++;
      $display("Test %s: FAIL with %0d errors", name, err_cnt - test_err);
    end
    test_err = err_cnt;
  endtask

  initial begin
    int r0;
    int n;
    int toggles;
    logic led_last;
    rst_n    = 1'b0;
    rx_valid = 1'b0;
    rx_data  = 8'h00;
    test_err = 0;
    repeat (2) @(posedge pin_clk);
    rst_n <= 1'b1;
    repeat (3) @(posedge pin_clk);

    assert (pin_cs && !pin_sck && pin_programn && pin_pu && pin_io2 && pin_io3 && pin_led)
      else report_error("pins not idle after reset");
    assert (!tx_valid && !usb_tx_en && !busy) else report_error("strobes active after reset");
    end_test("reset_state");

    tx_q.delete();
    r0 = cs_rises;
    read_cmd(12'h120, 8);
    wait_idle();
    check_read(12'h120, 8, r0);
    end_test("flash_read");

    for (int k = 0; k < 16; k++) begin
      rng = xorshift(rng);
      pattern[k] = rng[7:0];
    end
    r0 = cs_rises;
    send_byte(8'h02);
    send_byte(8'd20);
    send_byte(8'd0);
    send_byte(8'h02);
    send_byte(8'h00);
    send_byte(8'h02);
    send_byte(8'h00);
    for (int k = 0; k < 16; k++) send_byte(pattern[k]);
    wait_idle();
    tx_q.delete();
    read_cmd(12'h200, 16);
    wait_idle();
    assert (tx_q.size() == 16) else report_error("readback length wrong");
    for (int k = 0; k < 16 && k < tx_q.size(); k++)
      assert (tx_q[k] == pattern[k])
        else report_error($sformatf("readback %0d is %h, want %h", k, tx_q[k], pattern[k]));
    assert (cs_rises == r0 + 2) else report_error("cs rise count wrong for program and read");
    end_test("program_readback");

    tx_q.delete();
    r0 = cs_rises;
    send_byte(8'h02);
    send_byte(8'd0);
    send_byte(8'd0);
    repeat (40) @(posedge pin_clk);
    assert (cs_rises == r0 && pin_cs && tx_q.size() == 0)
      else report_error("empty command touched the bus");
    end_test("spi_framing");

    tx_q.delete();
    r0 = cs_rises;
    send_byte(8'hA5);
    repeat (40) @(posedge pin_clk);
    assert (cs_rises == r0 && tx_q.size() == 0) else report_error("unknown opcode acted");
    send_byte(8'h02);
    send_byte(8'd4);
    send_byte(8'd2);
    send_byte(8'h03);
    @(posedge pin_clk);
    while (!busy) @(posedge pin_clk);
    rx_valid <= 1'b1; // Sent during a write byte, must not become write data.
    rx_data  <= 8'h02;
    @(posedge pin_clk);
    rx_valid <= 1'b0;
    send_byte(8'h00);
    send_byte(8'h03);
    send_byte(8'h45);
    wait_idle();
    check_read(12'h345, 2, r0);
    repeat (40) @(posedge pin_clk);
    assert (cs_rises == r0 + 1 && tx_q.size() == 2) else report_error("dropped byte acted");
    end_test("dropped_bytes");

    send_byte(8'h01);
    n = 0;
    toggles = 0;
    led_last = pin_led;
    while (pin_programn && n < 1000) begin
      @(posedge pin_clk);
      #1;
      n++;
      if (pin_led != led_last) toggles++;
      led_last = pin_led;
    end
    assert (n == 256) else report_error($sformatf("programn fell after %0d cycles", n));
    assert (toggles > 2) else report_error("led did not toggle during the boot delay");
    repeat (50) begin
      @(posedge pin_clk);
      assert (!pin_programn) else report_error("programn rose again");
    end
    end_test("boot_delay");

    $display("Tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+common
common/boot_pkg.sv
common/spi_xfer_if.sv
bootloader/cmd_engine.sv
bootloader/spi_master.sv
rtl/boot_sequencer.sv
rtl/boot_top.sv
tests/flash_model.sv
tests/tb_boot.sv

/* Makefile */
SRCS = common/boot_settings.svh common/boot_pkg.sv common/spi_xfer_if.sv \
       bootloader/cmd_engine.sv bootloader/spi_master.sv \
       rtl/boot_sequencer.sv rtl/boot_top.sv \
       tests/flash_model.sv tests/tb_boot.sv

.PHONY: all run clean

all: obj_dir/Vtb_boot

obj_dir/Vtb_boot: sim.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f sim.f \
	  --top-module tb_boot -Mdir obj_dir -o Vtb_boot

run: obj_dir/Vtb_boot
	./obj_dir/Vtb_boot > run.log 2>&1; cat run.log
	grep -q "Done: no errors" run.log

clean:
	rm -rf obj_dir run.log
